/* rtl/mmio_null_defs.svh */
// MMIO null endpoint definitions
`ifndef MMIO_NULL_DEFS_SVH
`define MMIO_NULL_DEFS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
`define MN_ADDR_W 17   // Byte address
`define MN_DATA_W 64
`define MN_TAG_W  10
`define MN_FUNC_W 3

// ---------------------------------------------------------------------------
// Feature register byte offsets
// ---------------------------------------------------------------------------
`define MN_OFS_DFH     17'h0_0000
`define MN_OFS_GUID_L  17'h0_0008
`define MN_OFS_GUID_H  17'h0_0010
`define MN_OFS_SCRATCH 17'h0_0018

// GUID pairs selected per function
`define MN_NULL_GUID_L   64'haa31_f54a_3e40_3501
`define MN_NULL_GUID_H   64'h3e7b_60a0_df2d_4850
`define MN_VIRTIO_GUID_L 64'hb9ab_efbd_90b9_70c4
`define MN_VIRTIO_GUID_H 64'h1aae_155c_acc5_4210

// Type 1, end of list, id 0, version 0
`define MN_DFH_VALUE   64'h1000_0100_0000_0000
`define MN_DEBUG_RESET 32'hdead_beef

`define MN_CPL_DEPTH 4  // Completion queue entries per function

`endif

/* rtl/mmio_null_pkg.sv */
// MMIO null endpoint types
`include "mmio_null_defs.svh"

package mmio_null_pkg;

   // ------------------------------------------------------------------------
   // Field vectors
   // ------------------------------------------------------------------------
   typedef logic [`MN_ADDR_W-1:0] mmio_addr_t;  // Byte address
   typedef logic [`MN_DATA_W-1:0] mmio_data_t;
   typedef logic [`MN_TAG_W-1:0]  mmio_tag_t;   // Echoed on completion
   typedef logic [`MN_FUNC_W-1:0] func_num_t;

   // ------------------------------------------------------------------------
   // Completion arbiter FSM
   // ------------------------------------------------------------------------
   // Idle means the output register is empty
   typedef enum logic [0:0] {
      ARB_IDLE = 1'b0,
      ARB_HOLD = 1'b1
   } arb_state_e;

endpackage

/* rtl/null_csr_func.sv */
// Null accelerator function
`timescale 1ns/100ps
`include "mmio_null_defs.svh"

module null_csr_func
   import mmio_null_pkg::*;
#(
   parameter int FUNC_NUM        = 0,
   parameter bit IS_VF           = 1'b0,
   parameter bit USE_VIRTIO_GUID = 1'b0
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       i_flr_rst_n,
   output logic       o_flr_ack,
   input  logic       i_req_valid,
   input  logic       i_req_ready,
   input  logic       i_req_write,
   input  logic       i_req_vf_active,
   input  func_num_t  i_req_func,
   input  mmio_tag_t  i_req_tag,
   input  logic       i_req_len2,
   input  mmio_addr_t i_req_addr,
   input  mmio_data_t i_req_data,
   input  logic       i_cq_pop,
   output logic       o_cq_valid,
   output mmio_tag_t  o_cq_tag,
   output logic       o_cq_len2,
   output func_num_t  o_cq_func,
   output logic       o_cq_vf_active,
   output mmio_data_t o_cq_data,
   output logic       o_cq_afull
);
   localparam int DEPTH = `MN_CPL_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam mmio_data_t GUID_L = USE_VIRTIO_GUID ? `MN_VIRTIO_GUID_L : `MN_NULL_GUID_L;
   localparam mmio_data_t GUID_H = USE_VIRTIO_GUID ? `MN_VIRTIO_GUID_H : `MN_NULL_GUID_H;

   logic        req_take_q;
   logic        req_write_q;
   logic        req_vf_q;
   func_num_t   req_func_q;
   mmio_tag_t   req_tag_q;
   logic        req_len2_q;
   mmio_addr_t  req_addr_q;
   mmio_data_t  req_data_q;
   logic        func_hit;
   logic        wr_en;
   logic        rd_en;
   logic        upper32;        // 1-DW access at odd DW
   logic        unmapped;
   mmio_addr_t  ofs;            // 8-byte aligned offset
   mmio_data_t  rd_word;
   mmio_data_t  rd_data;
   mmio_data_t  scratch_q;
   logic [31:0] debug_q;
   logic        flr_d;

   mmio_tag_t        cq_tag_mem  [DEPTH];
   logic             cq_len2_mem [DEPTH];
   func_num_t        cq_func_mem [DEPTH];
   logic             cq_vf_mem   [DEPTH];
   mmio_data_t       cq_data_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // ------------------------------------------------------------------------
   // Request stage
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_take_q <= 1'b0;
      end else begin
         req_take_q <= i_req_valid & i_req_ready;
      end
   end

   always_ff @(posedge clk) begin
      req_write_q <= i_req_write;
      req_vf_q    <= i_req_vf_active;
      req_func_q  <= i_req_func;
      req_tag_q   <= i_req_tag;
      req_len2_q  <= i_req_len2;
      req_addr_q  <= i_req_addr;
      req_data_q  <= i_req_data;
   end

   always_comb begin
      func_hit = req_take_q && (req_vf_q == IS_VF) &&
                 (req_func_q == func_num_t'(FUNC_NUM));
      wr_en    = func_hit & req_write_q;
      rd_en    = func_hit & ~req_write_q;
      ofs      = {req_addr_q[`MN_ADDR_W-1:3], 3'b000};
      upper32  = ~req_len2_q & req_addr_q[2];
   end

   // Register read mux
   always_comb begin
      unmapped = 1'b0;
      case (ofs)
         `MN_OFS_DFH:     rd_word = `MN_DFH_VALUE;
         `MN_OFS_GUID_L:  rd_word = GUID_L;
         `MN_OFS_GUID_H:  rd_word = GUID_H;
         `MN_OFS_SCRATCH: rd_word = scratch_q;
         default: begin
            unmapped = 1'b1;
            rd_word  = {debug_q, 32'(ofs)};  // Debug word plus decoded offset
         end
      endcase
      rd_data = (upper32 && !unmapped) ? {32'h0, rd_word[63:32]} : rd_word;
   end

   // Scratchpad and debug word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch_q <= '0;
         debug_q   <= `MN_DEBUG_RESET;
      end else if (wr_en) begin
         if (ofs == `MN_OFS_SCRATCH) begin
            scratch_q <= upper32 ? {2{req_data_q[31:0]}} : req_data_q;
         end else if (unmapped) begin
            scratch_q <= 64'h0000_0000_aaaa_aaaa;
            debug_q   <= 32'hbbbb_bbbb;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Completion queue
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rd_en) begin
         cq_tag_mem[wr_ptr]  <= req_tag_q;
         cq_len2_mem[wr_ptr] <= req_len2_q;
         cq_func_mem[wr_ptr] <= req_func_q;
         cq_vf_mem[wr_ptr]   <= req_vf_q;
         cq_data_mem[wr_ptr] <= rd_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (rd_en) wr_ptr <= ptr_inc(wr_ptr);
         if (i_cq_pop) rd_ptr <= ptr_inc(rd_ptr);
         case ({rd_en, i_cq_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign o_cq_valid     = (count != '0);
   assign o_cq_afull     = (count >= (PTR_W + 1)'(DEPTH - 1));  // One slot or less free
   assign o_cq_tag       = cq_tag_mem[rd_ptr];
   assign o_cq_len2      = cq_len2_mem[rd_ptr];
   assign o_cq_func      = cq_func_mem[rd_ptr];
   assign o_cq_vf_active = cq_vf_mem[rd_ptr];
   assign o_cq_data      = cq_data_mem[rd_ptr];

   // FLR acknowledge on falling edge
   always_ff @(posedge clk) begin
      flr_d <= i_flr_rst_n;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_flr_ack <= 1'b0;
      end else begin
         o_flr_ack <= flr_d & ~i_flr_rst_n;
      end
   end

endmodule

/* rtl/cpl_tx_arbiter.sv */
// Completion round-robin arbiter
`timescale 1ns/100ps

module cpl_tx_arbiter
   import mmio_null_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       i_cpl_ready,
   input  logic       i_cq0_valid,
   input  mmio_tag_t  i_cq0_tag,
   input  logic       i_cq0_len2,
   input  func_num_t  i_cq0_func,
   input  logic       i_cq0_vf_active,
   input  mmio_data_t i_cq0_data,
   input  logic       i_cq0_afull,
   input  logic       i_cq1_valid,
   input  mmio_tag_t  i_cq1_tag,
   input  logic       i_cq1_len2,
   input  func_num_t  i_cq1_func,
   input  logic       i_cq1_vf_active,
   input  mmio_data_t i_cq1_data,
   input  logic       i_cq1_afull,
   output logic       o_cq0_pop,
   output logic       o_cq1_pop,
   output logic       o_req_ready,
   output logic       o_cpl_valid,
   output mmio_tag_t  o_cpl_tag,
   output func_num_t  o_cpl_func,
   output logic       o_cpl_vf_active,
   output logic       o_cpl_len2,
   output mmio_data_t o_cpl_data
);
   arb_state_e state_q;
   arb_state_e state_d;
   logic       last_q;     // Set when queue 1 won last
   logic       load_en;
   logic       grant0;
   logic       grant1;

   always_comb begin
      load_en = (state_q == ARB_IDLE) | i_cpl_ready;  // Empty or being taken
      grant0  = i_cq0_valid & (~i_cq1_valid | last_q);
      grant1  = i_cq1_valid & ~grant0;
      state_d = state_q;
      if (load_en) state_d = (grant0 | grant1) ? ARB_HOLD : ARB_IDLE;
   end

   assign o_cq0_pop   = load_en & grant0;
   assign o_cq1_pop   = load_en & grant1;
   assign o_cpl_valid = (state_q == ARB_HOLD);
   assign o_req_ready = ~(i_cq0_afull | i_cq1_afull);  // Room for the in-flight read

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= ARB_IDLE;
         last_q  <= 1'b1;
      end else begin
         state_q <= state_d;
         if (o_cq0_pop | o_cq1_pop) last_q <= o_cq1_pop;
      end
   end

   // Output register held while stalled
   always_ff @(posedge clk) begin
      if (o_cq0_pop) begin
         {o_cpl_tag, o_cpl_func, o_cpl_vf_active} <= {i_cq0_tag, i_cq0_func, i_cq0_vf_active};
         {o_cpl_len2, o_cpl_data}                 <= {i_cq0_len2, i_cq0_data};
      end else if (o_cq1_pop) begin
         {o_cpl_tag, o_cpl_func, o_cpl_vf_active} <= {i_cq1_tag, i_cq1_func, i_cq1_vf_active};
         {o_cpl_len2, o_cpl_data}                 <= {i_cq1_len2, i_cq1_data};
      end
   end

endmodule

/* rtl/mmio_null_top.sv */
// MMIO null endpoint top
`timescale 1ns/100ps

module mmio_null_top
   import mmio_null_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       i_flr0_rst_n,
   input  logic       i_flr1_rst_n,
   output logic       o_flr0_ack,
   output logic       o_flr1_ack,
   input  logic       i_req_valid,
   input  logic       i_req_write,
   input  logic       i_req_vf_active,
   input  func_num_t  i_req_func,
   input  mmio_tag_t  i_req_tag,
   input  logic       i_req_len2,
   input  mmio_addr_t i_req_addr,
   input  mmio_data_t i_req_data,
   output logic       o_req_ready,
   output logic       o_cpl_valid,
   output mmio_tag_t  o_cpl_tag,
   output func_num_t  o_cpl_func,
   output logic       o_cpl_vf_active,
   output logic       o_cpl_len2,
   output mmio_data_t o_cpl_data,
   input  logic       i_cpl_ready
);
   // Queue 0 belongs to the PF
   logic       cq0_valid, cq0_len2, cq0_vf_active, cq0_afull, cq0_pop;
   logic       cq1_valid, cq1_len2, cq1_vf_active, cq1_afull, cq1_pop;
   mmio_tag_t  cq0_tag, cq1_tag;
   func_num_t  cq0_func, cq1_func;
   mmio_data_t cq0_data, cq1_data;

   null_csr_func #(.FUNC_NUM(0), .IS_VF(1'b0), .USE_VIRTIO_GUID(1'b0)) u_func_pf (
      .clk, .rst_n, .i_flr_rst_n(i_flr0_rst_n), .o_flr_ack(o_flr0_ack),
      .i_req_valid, .i_req_ready(o_req_ready), .i_req_write, .i_req_vf_active,
      .i_req_func, .i_req_tag, .i_req_len2, .i_req_addr, .i_req_data,
      .i_cq_pop(cq0_pop), .o_cq_valid(cq0_valid), .o_cq_tag(cq0_tag), .o_cq_len2(cq0_len2),
      .o_cq_func(cq0_func), .o_cq_vf_active(cq0_vf_active), .o_cq_data(cq0_data),
      .o_cq_afull(cq0_afull)
   );

   null_csr_func #(.FUNC_NUM(0), .IS_VF(1'b1), .USE_VIRTIO_GUID(1'b1)) u_func_vf (
      .clk, .rst_n, .i_flr_rst_n(i_flr1_rst_n), .o_flr_ack(o_flr1_ack),
      .i_req_valid, .i_req_ready(o_req_ready), .i_req_write, .i_req_vf_active,
      .i_req_func, .i_req_tag, .i_req_len2, .i_req_addr, .i_req_data,
      .i_cq_pop(cq1_pop), .o_cq_valid(cq1_valid), .o_cq_tag(cq1_tag), .o_cq_len2(cq1_len2),
      .o_cq_func(cq1_func), .o_cq_vf_active(cq1_vf_active), .o_cq_data(cq1_data),
      .o_cq_afull(cq1_afull)
   );

   cpl_tx_arbiter u_arb (
      .clk, .rst_n, .i_cpl_ready,
      .i_cq0_valid(cq0_valid), .i_cq0_tag(cq0_tag), .i_cq0_len2(cq0_len2),
      .i_cq0_func(cq0_func), .i_cq0_vf_active(cq0_vf_active), .i_cq0_data(cq0_data),
      .i_cq0_afull(cq0_afull),
      .i_cq1_valid(cq1_valid), .i_cq1_tag(cq1_tag), .i_cq1_len2(cq1_len2),
      .i_cq1_func(cq1_func), .i_cq1_vf_active(cq1_vf_active), .i_cq1_data(cq1_data),
      .i_cq1_afull(cq1_afull),
      .o_cq0_pop(cq0_pop), .o_cq1_pop(cq1_pop), .o_req_ready,
      .o_cpl_valid, .o_cpl_tag, .o_cpl_func, .o_cpl_vf_active, .o_cpl_len2, .o_cpl_data
   );

endmodule

/* verification/tb_mmio_null.sv */
// MMIO null endpoint testbench
`timescale 1ns/100ps
`include "mmio_null_defs.svh"

module tb_mmio_null
   import mmio_null_pkg::*;
();
   localparam int PF_FUNC   = 0;
   localparam int VF_FUNC   = 0;
   localparam int MAX_LINES = 64;
   localparam int N_TAGS    = 1 << `MN_TAG_W;
   localparam int CPL_W     = `MN_TAG_W + `MN_FUNC_W + `MN_DATA_W + 2;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       flr0_n;
   logic       flr1_n;
   logic       flr0_ack;
   logic       flr1_ack;
   logic       req_valid;
   logic       req_write;
   logic       req_vf;
   func_num_t  req_func;
   mmio_tag_t  req_tag;
   logic       req_len2;
   mmio_addr_t req_addr;
   mmio_data_t req_data;
   logic       req_ready;
   logic       cpl_valid;
   mmio_tag_t  cpl_tag;
   func_num_t  cpl_func;
   logic       cpl_vf;
   logic       cpl_len2;
   mmio_data_t cpl_data;
   logic       cpl_ready;
   logic       drain = 1'b0;          // Stops the completion stalls
   logic       loaded = 1'b0;
   logic       stalled = 1'b0;
   logic [CPL_W-1:0] held_cpl;
   logic [CPL_W-1:0] cur_cpl;

   // Request list from the data file
   logic       ln_write [MAX_LINES];
   logic       ln_vf    [MAX_LINES];
   func_num_t  ln_func  [MAX_LINES];
   mmio_tag_t  ln_tag   [MAX_LINES];
   logic       ln_len2  [MAX_LINES];
   mmio_addr_t ln_addr  [MAX_LINES];
   mmio_data_t ln_wdata [MAX_LINES];
   mmio_data_t ln_rdata [MAX_LINES];
   int         n_lines = 0;

   // Outstanding reads indexed by tag
   logic       exp_pend [N_TAGS];
   mmio_data_t exp_data [N_TAGS];
   logic       exp_vf   [N_TAGS];
   func_num_t  exp_func [N_TAGS];
   logic       exp_len2 [N_TAGS];
   int         exp_count = 0;
   int         cpl_count = 0;
   int         mism_errs = 0;
   int         other_errs = 0;

   mmio_null_top u_dut (
      .clk, .rst_n, .i_flr0_rst_n(flr0_n), .i_flr1_rst_n(flr1_n),
      .o_flr0_ack(flr0_ack), .o_flr1_ack(flr1_ack),
      .i_req_valid(req_valid), .i_req_write(req_write), .i_req_vf_active(req_vf),
      .i_req_func(req_func), .i_req_tag(req_tag), .i_req_len2(req_len2),
      .i_req_addr(req_addr), .i_req_data(req_data), .o_req_ready(req_ready),
      .o_cpl_valid(cpl_valid), .o_cpl_tag(cpl_tag), .o_cpl_func(cpl_func),
      .o_cpl_vf_active(cpl_vf), .o_cpl_len2(cpl_len2), .o_cpl_data(cpl_data),
      .i_cpl_ready(cpl_ready)
   );

   always #2 clk = ~clk;

   assign cur_cpl = {cpl_tag, cpl_func, cpl_vf, cpl_len2, cpl_data};

   // PF and VF both sit at function number 0
   function automatic logic targets_function(input logic vf, input func_num_t fn);
      return (!vf && fn == func_num_t'(PF_FUNC)) || (vf && fn == func_num_t'(VF_FUNC));
   endfunction

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mism_errs++;
         $display("MISMATCH %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic score_completion();
      mmio_tag_t t;
      t = cpl_tag;
      cpl_count++;
      if (!exp_pend[t]) begin
         other_errs++;
         $display("Completion with an unexpected or repeated tag %h", t);
      end else begin
         if (cpl_data !== exp_data[t]) begin
            mism_errs++;
            $display("MISMATCH o_cpl_data tag %h: expected %h, got %h", t, exp_data[t], cpl_data);
         end
         compare_bit("o_cpl_vf_active", cpl_vf, exp_vf[t]);
         compare_bit("o_cpl_len2", cpl_len2, exp_len2[t]);
         if (cpl_func !== exp_func[t]) begin
            mism_errs++;
            $display("MISMATCH o_cpl_func tag %h: expected %h, got %h", t, exp_func[t], cpl_func);
         end
         exp_pend[t] = 1'b0;
      end
   endtask

   task automatic run_flr_test(input int fn);
      int   pulses;
      int   first;
      int   cyc;
      logic ack;
      logic other;
      pulses = 0;
      first  = -1;
      @(posedge clk);
      if (fn == 0) flr0_n <= 1'b0;
      else flr1_n <= 1'b0;
      for (cyc = 0; cyc < 8; cyc++) begin
         @(negedge clk);
         ack   = (fn == 0) ? flr0_ack : flr1_ack;
         other = (fn == 0) ? flr1_ack : flr0_ack;
         if (ack) begin
            pulses++;
            if (first < 0) first = cyc;
         end
         if (other) begin
            other_errs++;
            $display("FLR acknowledge on the wrong function during FLR of function %0d", fn);
         end
         if (cyc == 3) begin
            @(posedge clk);        // No pulse expected on the release
            if (fn == 0) flr0_n <= 1'b1;
            else flr1_n <= 1'b1;
         end
      end
      if (pulses != 1 || first != 1) begin
         other_errs++;
         $display("FLR of function %0d gave %0d acknowledge pulses, first at cycle %0d",
                  fn, pulses, first);
      end
   endtask

   // ------------------------------------------------------------------------
   // Completion monitor and stall source
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      if (rst_n && cpl_valid) begin
         if (stalled && cur_cpl !== held_cpl) begin
            mism_errs++;
            $display("MISMATCH o_cpl fields while stalled: expected %h, got %h",
                     held_cpl, cur_cpl);
         end
         if (cpl_ready) begin
            score_completion();
            stalled = 1'b0;
         end else begin
            stalled  = 1'b1;
            held_cpl = cur_cpl;
         end
      end
   end

   initial begin
      void'($urandom(32'h4289_6f25));
      cpl_ready = 1'b0;
      forever begin
         @(posedge clk);
         cpl_ready <= drain | (($urandom % 8) < 5);  // Ready about 5 cycles in 8
      end
   end

   initial begin
      wait (loaded);
      repeat (n_lines * 40 + 200) @(posedge clk);
      $display("Timeout, the run did not complete in %0d cycles", n_lines * 40 + 200);
      $display("Errors: %0d mismatches, %0d other", mism_errs, other_errs);
      $display("*** FAILED ***");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      int         fd;
      int         cnt;
      int         op;
      int         vf;
      int         fn;
      int         tag;
      int         len2;
      int         i;
      string      line;
      mmio_addr_t addr;
      mmio_data_t wdata;
      mmio_data_t rdata;
      rst_n     = 1'b0;
      flr0_n    = 1'b1;
      flr1_n    = 1'b1;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_vf    = 1'b0;
      req_func  = '0;
      req_tag   = '0;
      req_len2  = 1'b0;
      req_addr  = '0;
      req_data  = '0;
      for (i = 0; i < N_TAGS; i++) exp_pend[i] = 1'b0;

      fd = $fopen("verification/mmio_null_testdata.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("Cannot open the test data file");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                             op, vf, fn, tag, len2, addr, wdata, rdata);
               if (cnt != 8 || n_lines >= MAX_LINES) begin
                  other_errs++;
                  $display("Bad or surplus test data line after request %0d", n_lines);
               end else begin
                  ln_write[n_lines] = (op == 1);
                  ln_vf[n_lines]    = (vf != 0);
                  ln_func[n_lines]  = func_num_t'(fn);
                  ln_tag[n_lines]   = mmio_tag_t'(tag);
                  ln_len2[n_lines]  = (len2 != 0);
                  ln_addr[n_lines]  = addr;
                  ln_wdata[n_lines] = wdata;
                  ln_rdata[n_lines] = rdata;
                  n_lines++;
               end
            end
         end
         $fclose(fd);
      end
      if (n_lines == 0) begin
         other_errs++;
         $display("No requests were loaded from the test data file");
      end
      loaded = 1'b1;

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      compare_bit("o_cpl_valid", cpl_valid, 1'b0);
      compare_bit("o_req_ready", req_ready, 1'b1);
      compare_bit("o_flr0_ack", flr0_ack, 1'b0);
      compare_bit("o_flr1_ack", flr1_ack, 1'b0);

      @(posedge clk);
      for (i = 0; i < n_lines; i++) begin
         req_valid <= 1'b1;
         req_write <= ln_write[i];
         req_vf    <= ln_vf[i];
         req_func  <= ln_func[i];
         req_tag   <= ln_tag[i];
         req_len2  <= ln_len2[i];
         req_addr  <= ln_addr[i];
         req_data  <= ln_wdata[i];
         if (!ln_write[i] && targets_function(ln_vf[i], ln_func[i])) begin
            exp_pend[ln_tag[i]] = 1'b1;
            exp_data[ln_tag[i]] = ln_rdata[i];
            exp_vf[ln_tag[i]]   = ln_vf[i];
            exp_func[ln_tag[i]] = ln_func[i];
            exp_len2[ln_tag[i]] = ln_len2[i];
            exp_count++;
         end
         do @(negedge clk); while (!req_ready);  // Taken on the next edge
         @(posedge clk);
      end
      req_valid <= 1'b0;

      while (cpl_count < exp_count) @(posedge clk);
      drain <= 1'b1;
      repeat (20) @(posedge clk);         // Room for any stray completion
      for (i = 0; i < N_TAGS; i++) begin
         if (exp_pend[i]) begin
            other_errs++;
            $display("No completion arrived for tag %h", i);
         end
      end
      if (cpl_count != exp_count) begin
         other_errs++;
         $display("Received %0d completions where %0d were expected", cpl_count, exp_count);
      end

      run_flr_test(0);
      run_flr_test(1);

      $display("Errors: %0d mismatches, %0d other, %0d completions received",
               mism_errs, other_errs, cpl_count);
      if (mism_errs == 0 && other_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* verification/mmio_null_testdata.txt */
# op(0 read, 1 write) vf func tag len2 addr wdata expected_read_data, all hex
# PF is vf 0 func 0, VF is vf 1 func 0, any other pair is dropped
0 0 0 001 1 00000 0 1000010000000000
0 0 0 002 1 00008 0 aa31f54a3e403501
0 0 0 003 1 00010 0 3e7b60a0df2d4850
0 1 0 004 1 00000 0 1000010000000000
0 1 0 005 1 00008 0 b9abefbd90b970c4
0 1 0 006 1 00010 0 1aae155cacc54210
0 0 0 007 0 0000c 0 00000000aa31f54a
0 1 0 008 0 00014 0 000000001aae155c
0 0 0 009 1 00020 0 deadbeef00000020
0 1 0 00a 1 00038 0 deadbeef00000038
1 0 0 00b 1 00018 0123456789abcdef 0
1 1 0 00c 1 00018 fedcba9876543210 0
0 0 0 00d 1 00018 0 0123456789abcdef
0 1 0 00e 1 00018 0 fedcba9876543210
1 0 0 00f 0 0001c 00000000cafef00d 0
0 0 0 010 1 00018 0 cafef00dcafef00d
0 1 0 011 1 00018 0 fedcba9876543210
0 0 0 012 0 0001c 0 00000000cafef00d
0 0 1 013 1 00000 0 0
0 1 2 014 1 00000 0 0
1 0 3 015 1 00018 1111111111111111 0
0 0 0 016 1 00018 0 cafef00dcafef00d
1 1 0 017 1 00040 5555555555555555 0
0 1 0 018 1 00018 0 00000000aaaaaaaa
0 1 0 019 1 00028 0 bbbbbbbb00000028
0 0 0 01a 1 00028 0 deadbeef00000028
0 0 0 01b 1 00008 0 aa31f54a3e403501
0 1 0 01c 1 00010 0 1aae155cacc54210

/* tb.f */
+incdir+rtl
rtl/mmio_null_pkg.sv
rtl/null_csr_func.sv
rtl/cpl_tx_arbiter.sv
rtl/mmio_null_top.sv
verification/tb_mmio_null.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_mmio_null -Mdir obj_dir
out=$(./obj_dir/Vtb_mmio_null)
echo "$out"

if echo "$out" | grep -qF -- '*** PASSED ***'; then
   exit 0
fi
exit 1
